//--- axi4_burst_mem_slave.sv
/*
  Output side of the write subsystem
  AXI4 write slave over a word-addressed memory
  INCR addressing, byte strobes, range and length checks
  Registered read-back port
*/
`timescale 1ns/1ns
`default_nettype none
`include "axi_wr_consts.svh"

module axi4_burst_mem_slave (
  input  wire                              clk,
  input  wire                              rst_n,

  // AW
  input  wire  axi4_types_pkg::slv_id_t    slv_awid,
  input  wire  axi4_types_pkg::addr_t      slv_awaddr,
  input  wire  axi4_types_pkg::len_t       slv_awlen,
  input  wire                              slv_awvalid,
  output logic                             slv_awready,

  // W
  input  wire  axi4_types_pkg::data_t      slv_wdata,
  input  wire  axi4_types_pkg::strb_t      slv_wstrb,
  input  wire                              slv_wlast,
  input  wire                              slv_wvalid,
  output logic                             slv_wready,

  // B
  output axi4_types_pkg::slv_id_t          slv_bid,
  output axi4_types_pkg::resp_t            slv_bresp,
  output logic                             slv_bvalid,
  input  wire                              slv_bready,

  // Read-back
  input  wire  wr_arb_pkg::word_addr_t     rd_addr,
  output axi4_types_pkg::data_t            rd_data
);
  import axi4_types_pkg::*;
  import wr_arb_pkg::*;

  localparam int BYTE_SEL_W = $clog2(`AXI_STRB_W);
  // One spare bit so a burst near the top cannot wrap
  localparam int WPTR_W     = `AXI_ADDR_W - BYTE_SEL_W + 1;
  localparam int WORD_W     = $bits(word_addr_t);

  mem_state_t        state;
  data_t             mem [`MEM_WORDS];
  logic [WPTR_W-1:0] wptr;
  len_t              beats_left;
  slv_id_t           burst_id;
  logic              burst_err;
  logic              aw_hs;
  logic              w_hs;
  logic              b_hs;
  logic              beat_in_range;
  logic              len_bad;
  word_addr_t        beat_word;

  assign aw_hs = slv_awvalid && slv_awready;
  assign w_hs  = slv_wvalid && slv_wready;
  assign b_hs  = slv_bvalid && slv_bready;

  // Beat address checks
  assign beat_in_range = (wptr < WPTR_W'(`MEM_WORDS));
  assign beat_word     = wptr[WORD_W-1:0];
  // wlast must match the awlen count
  assign len_bad       = slv_wlast != (beats_left == '0);

  // ----------------------------------------
  // Burst FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= MEM_IDLE;
      burst_err <= 1'b0;
    end else begin
      case (state)
        MEM_IDLE: begin
          if (aw_hs) begin
            state     <= MEM_BURST;
            // Longer than the supported maximum
            burst_err <= (slv_awlen > len_t'(`AXI_MAX_BEATS - 1));
          end
        end
        MEM_BURST: begin
          if (w_hs) begin
            if (!beat_in_range || len_bad) begin
              burst_err <= 1'b1;
            end
            if (slv_wlast) begin
              state <= MEM_RESP;
            end
          end
        end
        MEM_RESP: begin
          if (b_hs) begin
            state <= MEM_IDLE;
          end
        end
        default: state <= MEM_IDLE;
      endcase
    end
  end

  // Burst address, count and ID
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      burst_id   <= slv_awid;
      wptr       <= {1'b0, slv_awaddr[`AXI_ADDR_W-1:BYTE_SEL_W]};
      beats_left <= slv_awlen;
    end else if (w_hs) begin
      wptr       <= wptr + 1'b1;
      beats_left <= beats_left - 1'b1;
    end
  end

  // ----------------------------------------
  // Memory array
  // ----------------------------------------
  // Enabled bytes only, nothing past the end
  always_ff @(posedge clk) begin
    if (w_hs && beat_in_range) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (slv_wstrb[b]) begin
          mem[beat_word][8*b +: 8] <= slv_wdata[8*b +: 8];
        end
      end
    end
  end

  // One-cycle read-back
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  // Handshake outputs from the state
  assign slv_awready = (state == MEM_IDLE);
  assign slv_wready  = (state == MEM_BURST);
  assign slv_bvalid  = (state == MEM_RESP);
  assign slv_bid     = burst_id;
  assign slv_bresp   = burst_err ? RESP_SLVERR : RESP_OKAY;

endmodule

`default_nettype wire

//--- axi4_types_pkg.sv
/*
  AXI4 write channel field types
  Write response codes
  Fixed burst attributes driven toward the slave
*/
`default_nettype none
`include "axi_wr_consts.svh"

package axi4_types_pkg;

  // IDs, before and after master tagging
  typedef logic [`AXI_MST_ID_W-1:0] mst_id_t;
  typedef logic [`AXI_SLV_ID_W-1:0] slv_id_t;

  // Address and data beats
  typedef logic [`AXI_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_DATA_W-1:0] data_t;
  typedef logic [`AXI_STRB_W-1:0] strb_t;

  // Burst length, beats minus one
  typedef logic [7:0] len_t;
  typedef logic [1:0] resp_t;

  // Write response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Only full-word INCR bursts
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [2:0] AXI_SIZE_WORD  = 3'($clog2(`AXI_STRB_W));

endpackage

`default_nettype wire

//--- axi4_wr_id_tagger.sv
/*
  Input side of the write subsystem
  Prefixes each master's AW ID with its index
  Steers the write response back to the owning master
*/
`timescale 1ns/1ns
`default_nettype none
`include "axi_wr_consts.svh"

module axi4_wr_id_tagger (
  // AW IDs from the masters, tagged toward the arbiter
  input  wire  axi4_types_pkg::mst_id_t [`AXI_NR_MASTERS-1:0] mst_awid,
  output axi4_types_pkg::slv_id_t       [`AXI_NR_MASTERS-1:0] tag_awid,

  // B channel from the arbiter
  input  wire  axi4_types_pkg::slv_id_t                       slv_bid,
  input  wire  axi4_types_pkg::resp_t                         slv_bresp,
  input  wire                                                 slv_bvalid,
  output logic                                                slv_bready,

  // B channel toward the masters
  output axi4_types_pkg::mst_id_t       [`AXI_NR_MASTERS-1:0] mst_bid,
  output axi4_types_pkg::resp_t         [`AXI_NR_MASTERS-1:0] mst_bresp,
  output logic                          [`AXI_NR_MASTERS-1:0] mst_bvalid,
  input  wire                           [`AXI_NR_MASTERS-1:0] mst_bready
);
  import wr_arb_pkg::*;

  localparam mst_idx_t NR_MST = mst_idx_t'(`AXI_NR_MASTERS);

  mst_idx_t b_owner;

  // ----------------------------------------
  // Response owner
  // ----------------------------------------
  // Index bits sit above the master ID
  assign b_owner = slv_bid[`AXI_SLV_ID_W-1 -: `AXI_MIDX_W];

  // ----------------------------------------
  // Per-master tagging and steering
  // ----------------------------------------
  always_comb begin
    for (int m = 0; m < `AXI_NR_MASTERS; m++) begin
      // Tag goes on top, master ID unchanged below
      tag_awid[m]   = {mst_idx_t'(m), mst_awid[m]};
      // Tag stripped on the way back
      mst_bid[m]    = slv_bid[`AXI_MST_ID_W-1:0];
      mst_bresp[m]  = slv_bresp;
      // Only the owner sees bvalid
      mst_bvalid[m] = slv_bvalid && (b_owner == mst_idx_t'(m));
    end
  end

  // Owner's bready goes up
  // A tag with no master behind it is drained
  assign slv_bready = (b_owner < NR_MST) ? mst_bready[b_owner] : 1'b1;

endmodule

`default_nettype wire

//--- axi4_write_arbiter.sv
/*
  Processing part of the write subsystem
  Round-robin grant, one whole burst per grant
  AW and W multiplexer toward the slave
  B pass-through held until the response handshake
*/
`timescale 1ns/1ns
`default_nettype none
`include "axi_wr_consts.svh"

module axi4_write_arbiter (
  input  wire                                                 clk,
  input  wire                                                 rst_n,

  // Master AW, IDs already tagged
  input  wire  axi4_types_pkg::slv_id_t [`AXI_NR_MASTERS-1:0] tag_awid,
  input  wire  axi4_types_pkg::addr_t   [`AXI_NR_MASTERS-1:0] mst_awaddr,
  input  wire  axi4_types_pkg::len_t    [`AXI_NR_MASTERS-1:0] mst_awlen,
  input  wire                           [`AXI_NR_MASTERS-1:0] mst_awvalid,
  output logic                          [`AXI_NR_MASTERS-1:0] mst_awready,

  // Master W
  input  wire  axi4_types_pkg::data_t   [`AXI_NR_MASTERS-1:0] mst_wdata,
  input  wire  axi4_types_pkg::strb_t   [`AXI_NR_MASTERS-1:0] mst_wstrb,
  input  wire                           [`AXI_NR_MASTERS-1:0] mst_wlast,
  input  wire                           [`AXI_NR_MASTERS-1:0] mst_wvalid,
  output logic                          [`AXI_NR_MASTERS-1:0] mst_wready,

  // Slave AW
  output axi4_types_pkg::slv_id_t                             slv_awid,
  output axi4_types_pkg::addr_t                               slv_awaddr,
  output axi4_types_pkg::len_t                                slv_awlen,
  output logic                          [2:0]                 slv_awsize,
  output logic                          [1:0]                 slv_awburst,
  output logic                                                slv_awvalid,
  input  wire                                                 slv_awready,

  // Slave W
  output axi4_types_pkg::data_t                               slv_wdata,
  output axi4_types_pkg::strb_t                               slv_wstrb,
  output logic                                                slv_wlast,
  output logic                                                slv_wvalid,
  input  wire                                                 slv_wready,

  // B from the slave
  input  wire  axi4_types_pkg::slv_id_t                       slv_bid,
  input  wire  axi4_types_pkg::resp_t                         slv_bresp,
  input  wire                                                 slv_bvalid,
  output logic                                                slv_bready,

  // B toward the ID tagger
  output axi4_types_pkg::slv_id_t                             tag_bid,
  output axi4_types_pkg::resp_t                               tag_bresp,
  output logic                                                tag_bvalid,
  input  wire                                                 tag_bready
);
  import axi4_types_pkg::*;
  import wr_arb_pkg::*;

  localparam mst_idx_t LAST_MST = mst_idx_t'(`AXI_NR_MASTERS - 1);

  arb_state_t state;
  mst_idx_t   rr_ptr;
  mst_idx_t   grant;
  logic       in_data;
  logic       in_resp;

  assign in_data = (state == ARB_DATA);
  assign in_resp = (state == ARB_RESP);

  // ----------------------------------------
  // Grant FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= ARB_SCAN;
      rr_ptr <= '0;
      grant  <= '0;
    end else begin
      case (state)
        ARB_SCAN: begin
          // One master looked at per cycle
          rr_ptr <= (rr_ptr == LAST_MST) ? '0 : rr_ptr + 1'b1;
          if (mst_awvalid[rr_ptr]) begin
            grant <= rr_ptr;
            state <= ARB_DATA;
          end
        end
        ARB_DATA: begin
          // Burst ends on the wlast handshake
          if (slv_wvalid && slv_wready && slv_wlast) begin
            state <= ARB_RESP;
          end
        end
        ARB_RESP: begin
          // Grant held until B is taken
          if (slv_bvalid && slv_bready) begin
            state <= ARB_SCAN;
          end
        end
        default: state <= ARB_SCAN;
      endcase
    end
  end

  // ----------------------------------------
  // AW and W multiplexer
  // ----------------------------------------
  always_comb begin
    slv_awid    = tag_awid[grant];
    slv_awaddr  = mst_awaddr[grant];
    slv_awlen   = mst_awlen[grant];
    slv_wdata   = mst_wdata[grant];
    slv_wstrb   = mst_wstrb[grant];
    slv_wlast   = mst_wlast[grant];
    // Valids only while a burst is granted
    slv_awvalid = in_data && mst_awvalid[grant];
    slv_wvalid  = in_data && mst_wvalid[grant];
    // Readies reach the granted master only
    mst_awready        = '0;
    mst_wready         = '0;
    mst_awready[grant] = in_data && slv_awready;
    mst_wready[grant]  = in_data && slv_wready;
  end

  // Full-word INCR always
  assign slv_awsize  = AXI_SIZE_WORD;
  assign slv_awburst = AXI_BURST_INCR;

  // ----------------------------------------
  // B pass-through
  // ----------------------------------------
  assign tag_bid    = slv_bid;
  assign tag_bresp  = slv_bresp;
  assign tag_bvalid = in_resp && slv_bvalid;
  assign slv_bready = in_resp && tag_bready;

endmodule

`default_nettype wire

//--- axi_wr_consts.svh
/*
  Shared constants of the AXI4 write subsystem
  Bus widths, master count and tagging widths
  Memory depth and burst limit
*/
`ifndef AXI_WR_CONSTS_SVH
`define AXI_WR_CONSTS_SVH

// ----------------------------------------
// Master side
// ----------------------------------------
// Masters sharing the memory slave
`define AXI_NR_MASTERS 3
// ID width as seen by each master
`define AXI_MST_ID_W 4
// Master index carried above the ID
`define AXI_MIDX_W 2
// Slave-side ID, index tag plus master ID
`define AXI_SLV_ID_W (`AXI_MST_ID_W + `AXI_MIDX_W)

// ----------------------------------------
// Bus and memory
// ----------------------------------------
`define AXI_ADDR_W 16
`define AXI_DATA_W 32
`define AXI_STRB_W 4
// Depth in 32-bit words
`define MEM_WORDS 256
// Longest INCR burst accepted
`define AXI_MAX_BEATS 16

`endif

//--- axi_wr_subsys_top.sv
/*
  Top level of the AXI4 write subsystem
  ID tagger, round-robin arbiter, burst memory slave
*/
`timescale 1ns/1ns
`default_nettype none
`include "axi_wr_consts.svh"

module axi_wr_subsys_top (
  input  wire                                                 clk,
  input  wire                                                 rst_n,

  // Master AW
  input  wire  axi4_types_pkg::mst_id_t [`AXI_NR_MASTERS-1:0] mst_awid,
  input  wire  axi4_types_pkg::addr_t   [`AXI_NR_MASTERS-1:0] mst_awaddr,
  input  wire  axi4_types_pkg::len_t    [`AXI_NR_MASTERS-1:0] mst_awlen,
  input  wire                           [`AXI_NR_MASTERS-1:0] mst_awvalid,
  output logic                          [`AXI_NR_MASTERS-1:0] mst_awready,

  // Master W
  input  wire  axi4_types_pkg::data_t   [`AXI_NR_MASTERS-1:0] mst_wdata,
  input  wire  axi4_types_pkg::strb_t   [`AXI_NR_MASTERS-1:0] mst_wstrb,
  input  wire                           [`AXI_NR_MASTERS-1:0] mst_wlast,
  input  wire                           [`AXI_NR_MASTERS-1:0] mst_wvalid,
  output logic                          [`AXI_NR_MASTERS-1:0] mst_wready,

  // Master B
  output axi4_types_pkg::mst_id_t       [`AXI_NR_MASTERS-1:0] mst_bid,
  output axi4_types_pkg::resp_t         [`AXI_NR_MASTERS-1:0] mst_bresp,
  output logic                          [`AXI_NR_MASTERS-1:0] mst_bvalid,
  input  wire                           [`AXI_NR_MASTERS-1:0] mst_bready,

  // Memory read-back
  input  wire  wr_arb_pkg::word_addr_t                        rd_addr,
  output axi4_types_pkg::data_t                               rd_data
);
  import axi4_types_pkg::*;

  // ----------------------------------------
  // Internal channels
  // ----------------------------------------
  slv_id_t [`AXI_NR_MASTERS-1:0] tag_awid;
  slv_id_t slv_awid;
  addr_t   slv_awaddr;
  len_t    slv_awlen;
  logic    slv_awvalid;
  logic    slv_awready;
  data_t   slv_wdata;
  strb_t   slv_wstrb;
  logic    slv_wlast;
  logic    slv_wvalid;
  logic    slv_wready;
  // B, slave to arbiter
  slv_id_t slv_bid;
  resp_t   slv_bresp;
  logic    slv_bvalid;
  logic    slv_bready;
  // B, arbiter to tagger
  slv_id_t tag_bid;
  resp_t   tag_bresp;
  logic    tag_bvalid;
  logic    tag_bready;

  axi4_wr_id_tagger u_tagger (
    .mst_awid   (mst_awid),
    .tag_awid   (tag_awid),
    .slv_bid    (tag_bid),
    .slv_bresp  (tag_bresp),
    .slv_bvalid (tag_bvalid),
    .slv_bready (tag_bready),
    .mst_bid    (mst_bid),
    .mst_bresp  (mst_bresp),
    .mst_bvalid (mst_bvalid),
    .mst_bready (mst_bready)
  );

  // Slave handles INCR full words only, so size and burst stay open
  axi4_write_arbiter u_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .tag_awid    (tag_awid),
    .mst_awaddr  (mst_awaddr),
    .mst_awlen   (mst_awlen),
    .mst_awvalid (mst_awvalid),
    .mst_awready (mst_awready),
    .mst_wdata   (mst_wdata),
    .mst_wstrb   (mst_wstrb),
    .mst_wlast   (mst_wlast),
    .mst_wvalid  (mst_wvalid),
    .mst_wready  (mst_wready),
    .slv_awid    (slv_awid),
    .slv_awaddr  (slv_awaddr),
    .slv_awlen   (slv_awlen),
    .slv_awsize  (),
    .slv_awburst (),
    .slv_awvalid (slv_awvalid),
    .slv_awready (slv_awready),
    .slv_wdata   (slv_wdata),
    .slv_wstrb   (slv_wstrb),
    .slv_wlast   (slv_wlast),
    .slv_wvalid  (slv_wvalid),
    .slv_wready  (slv_wready),
    .slv_bid     (slv_bid),
    .slv_bresp   (slv_bresp),
    .slv_bvalid  (slv_bvalid),
    .slv_bready  (slv_bready),
    .tag_bid     (tag_bid),
    .tag_bresp   (tag_bresp),
    .tag_bvalid  (tag_bvalid),
    .tag_bready  (tag_bready)
  );

  axi4_burst_mem_slave u_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .slv_awid    (slv_awid),
    .slv_awaddr  (slv_awaddr),
    .slv_awlen   (slv_awlen),
    .slv_awvalid (slv_awvalid),
    .slv_awready (slv_awready),
    .slv_wdata   (slv_wdata),
    .slv_wstrb   (slv_wstrb),
    .slv_wlast   (slv_wlast),
    .slv_wvalid  (slv_wvalid),
    .slv_wready  (slv_wready),
    .slv_bid     (slv_bid),
    .slv_bresp   (slv_bresp),
    .slv_bvalid  (slv_bvalid),
    .slv_bready  (slv_bready),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI4 write subsystem testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f sources.f --top-module tb_top --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- sources.f
+incdir+.
axi4_types_pkg.sv
wr_arb_pkg.sv
axi4_wr_id_tagger.sv
axi4_write_arbiter.sv
axi4_burst_mem_slave.sv
axi_wr_subsys_top.sv
tb_properties.sv
tb_top.sv

//--- tb_properties.sv
/*
  Handshake assertions on the master ports of the write subsystem
  AW payload held until accepted, one wready at a time,
  B response held until accepted
*/
`timescale 1ns/1ns
`default_nettype none
`include "axi_wr_consts.svh"

module tb_properties (
  input wire                                                clk,
  input wire                                                rst_n,
  input wire axi4_types_pkg::mst_id_t [`AXI_NR_MASTERS-1:0] mst_awid,
  input wire axi4_types_pkg::addr_t   [`AXI_NR_MASTERS-1:0] mst_awaddr,
  input wire axi4_types_pkg::len_t    [`AXI_NR_MASTERS-1:0] mst_awlen,
  input wire                          [`AXI_NR_MASTERS-1:0] mst_awvalid,
  input wire                          [`AXI_NR_MASTERS-1:0] mst_awready,
  input wire                          [`AXI_NR_MASTERS-1:0] mst_wready,
  input wire axi4_types_pkg::resp_t   [`AXI_NR_MASTERS-1:0] mst_bresp,
  input wire                          [`AXI_NR_MASTERS-1:0] mst_bvalid,
  input wire                          [`AXI_NR_MASTERS-1:0] mst_bready
);

  // ----------------------------------------
  // Per-master channel rules
  // ----------------------------------------
  for (genvar m = 0; m < `AXI_NR_MASTERS; m++) begin : g_mst
    // Pending AW keeps valid, address, length and ID
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
      mst_awvalid[m] && !mst_awready[m] |=> mst_awvalid[m] && $stable(mst_awaddr[m])
        && $stable(mst_awlen[m]) && $stable(mst_awid[m]))
      else $error("AW payload of master %0d changed before awready", m);

    // Unaccepted B stays up with the same response
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
      mst_bvalid[m] && !mst_bready[m] |=> mst_bvalid[m] && $stable(mst_bresp[m]))
      else $error("B of master %0d dropped or changed before bready", m);
  end

  // Only the granted master may see wready
  w_grant_one: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(mst_wready))
    else $error("More than one master sees wready");

endmodule

`default_nettype wire

//--- tb_top.sv
/*
  Directed testbench of the AXI4 write subsystem
  Clock, reset, master burst driver, memory read-back
  Reference memory model, check task, watchdog and summary
*/
`timescale 1ns/1ns
`default_nettype none
`include "axi_wr_consts.svh"

module tb_top;
  import axi4_types_pkg::*;
  import wr_arb_pkg::*;

  localparam int NR_MST     = `AXI_NR_MASTERS;
  localparam int CLK_PERIOD = 40;
  // Rough cycle count of reset plus each test
  localparam int RUN_CYCLES = 20 + 40 + 60 + 100 + 80 + 100;

  logic                         clk;
  logic                         rst_n;
  mst_id_t    [NR_MST-1:0]      mst_awid;
  addr_t      [NR_MST-1:0]      mst_awaddr;
  len_t       [NR_MST-1:0]      mst_awlen;
  logic       [NR_MST-1:0]      mst_awvalid;
  logic       [NR_MST-1:0]      mst_awready;
  data_t      [NR_MST-1:0]      mst_wdata;
  strb_t      [NR_MST-1:0]      mst_wstrb;
  logic       [NR_MST-1:0]      mst_wlast;
  logic       [NR_MST-1:0]      mst_wvalid;
  logic       [NR_MST-1:0]      mst_wready;
  mst_id_t    [NR_MST-1:0]      mst_bid;
  resp_t      [NR_MST-1:0]      mst_bresp;
  logic       [NR_MST-1:0]      mst_bvalid;
  logic       [NR_MST-1:0]      mst_bready;
  word_addr_t                   rd_addr;
  data_t                        rd_data;

  // Beats queued per master, reference memory, bookkeeping
  data_t beat_data [NR_MST][`AXI_MAX_BEATS];
  strb_t beat_strb [NR_MST][`AXI_MAX_BEATS];
  data_t exp_mem [`MEM_WORDS];
  int    b_count [NR_MST];
  time   aw_time [NR_MST];
  time   b_time [NR_MST];
  bit    aw_seen [NR_MST];
  int    grant_log [$];
  int    n_checks;
  int    n_errors;

  axi_wr_subsys_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .mst_awid    (mst_awid),
    .mst_awaddr  (mst_awaddr),
    .mst_awlen   (mst_awlen),
    .mst_awvalid (mst_awvalid),
    .mst_awready (mst_awready),
    .mst_wdata   (mst_wdata),
    .mst_wstrb   (mst_wstrb),
    .mst_wlast   (mst_wlast),
    .mst_wvalid  (mst_wvalid),
    .mst_wready  (mst_wready),
    .mst_bid     (mst_bid),
    .mst_bresp   (mst_bresp),
    .mst_bvalid  (mst_bvalid),
    .mst_bready  (mst_bready),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
  );

  bind axi_wr_subsys_top tb_properties u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .mst_awid    (mst_awid),
    .mst_awaddr  (mst_awaddr),
    .mst_awlen   (mst_awlen),
    .mst_awvalid (mst_awvalid),
    .mst_awready (mst_awready),
    .mst_wready  (mst_wready),
    .mst_bresp   (mst_bresp),
    .mst_bvalid  (mst_bvalid),
    .mst_bready  (mst_bready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // B handshakes counted mid-cycle where both sides are settled
  always @(negedge clk) begin
    for (int m = 0; m < NR_MST; m++) begin
      if (rst_n && mst_bvalid[m] && mst_bready[m]) begin
        b_count[m] <= b_count[m] + 1;
      end
    end
  end

  // ----------------------------------------
  // Checking and reference model
  // ----------------------------------------
  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Strobed bytes replace the stored ones
  function automatic void apply_strobes(input int w, input data_t d, input strb_t s);
    for (int b = 0; b < `AXI_STRB_W; b++) begin
      if (s[b]) begin
        exp_mem[w][8*b +: 8] = d[8*b +: 8];
      end
    end
  endfunction

  task automatic load_random_beats(input int m, input int beats, input strb_t s);
    for (int i = 0; i < beats; i++) begin
      beat_data[m][i] = $urandom();
      beat_strb[m][i] = s;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    $display("test %s finished, %0d errors", name, n_errors - err0);
  endtask

  // ----------------------------------------
  // Master driver and read-back
  // ----------------------------------------
  // Starts and ends 2 ns after a rising edge
  // Readies sampled at the falling edge
  task automatic write_burst(input int m, input mst_id_t id, input addr_t addr,
                             input int beats, input int stall_at, input int b_hold);
    int    word;
    bit    bad_range;
    resp_t exp_resp;
    resp_t first_resp;
    bad_range = 1'b0;
    for (int i = 0; i < beats; i++) begin
      word = int'(addr >> 2) + i;
      if (word >= `MEM_WORDS) begin
        bad_range = 1'b1;
      end else begin
        apply_strobes(word, beat_data[m][i], beat_strb[m][i]);
      end
    end
    exp_resp = bad_range ? RESP_SLVERR : RESP_OKAY;
    // Address phase
    mst_awid[m]    = id;
    mst_awaddr[m]  = addr;
    mst_awlen[m]   = len_t'(beats - 1);
    mst_awvalid[m] = 1'b1;
    @(negedge clk);
    while (!mst_awready[m]) @(negedge clk);
    @(posedge clk);
    aw_time[m] = $time;
    aw_seen[m] = 1'b1;
    grant_log.push_back(m);
    #2;
    mst_awvalid[m] = 1'b0;
    // Data phase
    for (int i = 0; i < beats; i++) begin
      // Optional three-cycle gap before one beat
      if (i == stall_at) begin
        mst_wvalid[m] = 1'b0;
        repeat (3) @(posedge clk);
        #2;
      end
      mst_wdata[m]  = beat_data[m][i];
      mst_wstrb[m]  = beat_strb[m][i];
      mst_wlast[m]  = (i == beats - 1);
      mst_wvalid[m] = 1'b1;
      @(negedge clk);
      while (!mst_wready[m]) @(negedge clk);
      @(posedge clk);
      #2;
    end
    mst_wvalid[m] = 1'b0;
    mst_wlast[m]  = 1'b0;
    // Response phase
    // Bready held low for b_hold cycles
    mst_bready[m] = (b_hold == 0);
    @(negedge clk);
    while (!mst_bvalid[m]) @(negedge clk);
    first_resp = mst_bresp[m];
    if (b_hold > 0) begin
      repeat (b_hold) begin
        @(negedge clk);
        check_eq("mst_bvalid", 32'(mst_bvalid[m]), 32'h1);
        check_eq("mst_bresp", 32'(mst_bresp[m]), 32'(first_resp));
      end
      @(posedge clk);
      #2;
      mst_bready[m] = 1'b1;
      @(negedge clk);
    end
    check_eq("mst_bid", 32'(mst_bid[m]), 32'(id));
    check_eq("mst_bresp", 32'(mst_bresp[m]), 32'(exp_resp));
    @(posedge clk);
    b_time[m] = $time;
    #2;
    mst_bready[m] = 1'b0;
  endtask

  task automatic read_back_words(input int lo, input int n);
    for (int w = lo; w < lo + n; w++) begin
      rd_addr = word_addr_t'(w);
      @(posedge clk);
      #2;
      check_eq($sformatf("rd_data[%0d]", w), rd_data, exp_mem[w]);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic single_master_burst();
    int err0;
    err0 = n_errors;
    load_random_beats(0, 4, 4'hf);
    write_burst(0, 4'h5, 16'h0000, 4, -1, 0);
    read_back_words(0, 4);
    report_test("single burst", err0);
  endtask

  task automatic partial_strobe_write();
    int err0;
    err0 = n_errors;
    load_random_beats(1, 2, 4'hf);
    write_burst(1, 4'ha, 16'h0040, 2, -1, 0);
    // Bytes 0 and 2 in the first beat and byte 3 in the second
    load_random_beats(1, 2, 4'b0101);
    beat_strb[1][1] = 4'b1000;
    write_burst(1, 4'ha, 16'h0040, 2, -1, 0);
    read_back_words(16, 2);
    report_test("partial strobes", err0);
  endtask

  task automatic three_master_round_robin();
    int err0;
    int base [NR_MST];
    err0 = n_errors;
    for (int m = 0; m < NR_MST; m++) begin
      load_random_beats(m, 4, 4'hf);
      base[m] = b_count[m];
    end
    grant_log.delete();
    fork
      write_burst(0, 4'h1, 16'h0100, 4, -1, 0);
      write_burst(1, 4'h2, 16'h0200, 4, -1, 0);
      write_burst(2, 4'h3, 16'h0300, 4, -1, 0);
    join
    // Each grant one past the previous
    for (int i = 1; i < grant_log.size(); i++) begin
      check_eq("grant index", grant_log[i], (grant_log[i - 1] + 1) % NR_MST);
    end
    for (int m = 0; m < NR_MST; m++) begin
      check_eq($sformatf("b count master %0d", m), b_count[m] - base[m], 32'd1);
    end
    read_back_words(64, 4);
    read_back_words(128, 4);
    read_back_words(192, 4);
    report_test("three masters", err0);
  endtask

  task automatic out_of_range_burst();
    int err0;
    err0 = n_errors;
    // Words 254 to 257 with the last two past the end
    load_random_beats(2, 4, 4'hf);
    write_burst(2, 4'h7, 16'h03f8, 4, -1, 0);
    read_back_words(254, 2);
    read_back_words(0, 2);
    // Word 1024 onward would alias word 0 if truncated
    load_random_beats(2, 2, 4'hf);
    write_burst(2, 4'h7, 16'h1000, 2, -1, 0);
    read_back_words(0, 2);
    report_test("out of range", err0);
  endtask

  task automatic bready_back_pressure();
    int err0;
    err0 = n_errors;
    load_random_beats(0, 4, 4'hf);
    load_random_beats(1, 2, 4'hf);
    aw_seen[0] = 1'b0;
    fork
      write_burst(0, 4'h9, 16'h0080, 4, 2, 10);
      begin
        // Second master asks once the first one holds the grant
        wait (aw_seen[0]);
        @(posedge clk);
        #2;
        write_burst(1, 4'h4, 16'h00c0, 2, -1, 0);
      end
    join
    check_eq("master 1 awready after master 0 B", 32'(aw_time[1] > b_time[0]), 32'h1);
    read_back_words(32, 4);
    read_back_words(48, 2);
    report_test("back pressure", err0);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    void'($urandom(32'hdb42));
    clk         = 1'b0;
    rst_n       = 1'b0;
    mst_awid    = '0;
    mst_awaddr  = '0;
    mst_awlen   = '0;
    mst_awvalid = '0;
    mst_wdata   = '0;
    mst_wstrb   = '0;
    mst_wlast   = '0;
    mst_wvalid  = '0;
    mst_bready  = '0;
    rd_addr     = '0;
    n_checks    = 0;
    n_errors    = 0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    single_master_burst();
    partial_strobe_write();
    three_master_round_robin();
    out_of_range_burst();
    bready_back_pressure();
    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog at four times the expected run length
  initial begin
    #(RUN_CYCLES * 4 * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", RUN_CYCLES * 4);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- wr_arb_pkg.sv
/*
  Arbiter and memory slave types
  Master index, memory word index
  State encodings of both FSMs
*/
`default_nettype none
`include "axi_wr_consts.svh"

package wr_arb_pkg;

  // Index of a master, also the ID tag
  typedef logic [`AXI_MIDX_W-1:0] mst_idx_t;

  // Word index into the memory array
  typedef logic [$clog2(`MEM_WORDS)-1:0] word_addr_t;

  // Arbiter: search, burst in progress, wait for B
  typedef enum logic [1:0] {ARB_SCAN, ARB_DATA, ARB_RESP} arb_state_t;

  // Memory slave: accept AW, take beats, hold B
  typedef enum logic [1:0] {MEM_IDLE, MEM_BURST, MEM_RESP} mem_state_t;

endpackage

`default_nettype wire
